//--- conv_1x1_top.f
+incdir+design
design/cnn_data_pkg.sv
design/conv_1x1_ctrl_pkg.sv
design/cnn_fifo_delay.sv
design/conv_1x1_buffer_weights.sv
design/conv_1x1_decode.sv
design/conv_1x1_execute.sv
design/conv_1x1_result.sv
design/conv_1x1_top.sv
verification/conv_1x1_tb.sv

//--- design/cnn_data_pkg.sv
`include "conv_1x1_defs.svh"

package cnn_data_pkg;

	////////////////////////////////////////////////////////////
	// Scalar values
	////////////////////////////////////////////////////////////

	// Signed Q8.8 value, pixel channel or weight
	typedef logic signed [`CNN_DATA_WIDTH-1:0] cnn_data_t;

	// Q16.16 product of two values
	typedef logic signed [`CNN_PROD_WIDTH-1:0] cnn_prod_t;

	// Sum of two products, one guard bit
	typedef logic signed [`CNN_SUM_WIDTH-1:0] cnn_sum_t;

	////////////////////////////////////////////////////////////
	// Grouped values
	////////////////////////////////////////////////////////////

	// Two-channel pixel, into execute and out of result
	typedef struct packed {
		cnn_data_t ch0;
		cnn_data_t ch1;
	} cnn_pixel_t;

	// One sum per output channel
	typedef struct packed {
		cnn_sum_t sum0;
		cnn_sum_t sum1;
	} cnn_sum_pair_t;

endpackage

//--- design/cnn_fifo_delay.sv
`timescale 1ns/1ps

module cnn_fifo_delay #(
	parameter int DATA_WIDTH    = 16,
	parameter int DATA_DEPTH    = 4,
	parameter int POINTER_WIDTH = 2
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  write,
	input  logic                  read,
	input  logic [DATA_WIDTH-1:0] data_in,
	output logic [DATA_WIDTH-1:0] data_out,
	output logic                  full,
	output logic                  empty
);

	localparam logic [POINTER_WIDTH-1:0] PTR_LAST   = POINTER_WIDTH'(DATA_DEPTH - 1);
	localparam logic [POINTER_WIDTH:0]   COUNT_FULL = (POINTER_WIDTH + 1)'(DATA_DEPTH);

	logic [DATA_WIDTH-1:0]    mem [DATA_DEPTH];
	logic [POINTER_WIDTH-1:0] wr_ptr;
	logic [POINTER_WIDTH-1:0] rd_ptr;
	// One extra bit so full and empty differ
	logic [POINTER_WIDTH:0]   count;
	logic                     do_write;
	logic                     do_read;

	assign full     = (count == COUNT_FULL);
	assign empty    = (count == '0);
	assign do_read  = read && !empty;
	// A pop in the same cycle frees a slot
	assign do_write = write && (!full || do_read);

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage, read data lands one edge after the pop
	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= data_in;
		if (do_read)
			data_out <= mem[rd_ptr];
	end

	// Writer must not overrun a full buffer
	assert property (@(posedge clk) disable iff (reset) (write && full) |-> read);
	// Reader must not pop an empty buffer
	assert property (@(posedge clk) disable iff (reset) read |-> !empty);

endmodule

//--- design/conv_1x1_buffer_weights.sv
`timescale 1ns/1ps
`include "conv_1x1_defs.svh"

module conv_1x1_buffer_weights (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    w_write,
	input  cnn_data_pkg::cnn_data_t w_data,
	input  logic                    load_weights,
	output cnn_data_pkg::cnn_data_t buf_weight,
	output logic                    weights_loaded
);

	// Input stage, one cycle ahead of the FIFO write
	logic                    w_valid_q;
	cnn_data_pkg::cnn_data_t w_data_q;

	////////////////////////////////////////////////////////////
	// Input register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			w_valid_q <= 1'b0;
		else
			w_valid_q <= w_write;
	end

	always_ff @(posedge clk) begin
		if (w_write)
			w_data_q <= w_data;
	end

	////////////////////////////////////////////////////////////
	// Weight FIFO, four entries
	////////////////////////////////////////////////////////////

	cnn_fifo_delay #(
		.DATA_WIDTH   (`CNN_DATA_WIDTH),
		.DATA_DEPTH   (`CNN_WEIGHT_NUM),
		.POINTER_WIDTH(`CNN_WPTR_WIDTH)
	) u_fifo (
		.clk     (clk),
		.reset   (reset),
		.write   (w_valid_q),
		.read    (load_weights),
		.data_in (w_data_q),
		.data_out(buf_weight),
		.full    (),
		.empty   ()
	);

	// Sticky, sets on first fetch and stays until reset
	always_ff @(posedge clk) begin
		if (reset)
			weights_loaded <= 1'b0;
		else if (load_weights)
			weights_loaded <= 1'b1;
	end

endmodule

//--- design/conv_1x1_ctrl_pkg.sv
package conv_1x1_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// Input stream
	////////////////////////////////////////////////////////////

	// Tag on each stream word
	typedef enum logic {
		KIND_WEIGHT = 1'b0,
		KIND_PIXEL  = 1'b1
	} cnn_kind_e;

	// Tagged word, one per valid cycle
	typedef struct packed {
		cnn_kind_e               kind;
		cnn_data_pkg::cnn_data_t data;
	} cnn_word_t;

	////////////////////////////////////////////////////////////
	// Decode FSM
	////////////////////////////////////////////////////////////

	// LOAD collects weights, FETCH moves them into execute,
	// RUN pairs pixel words
	typedef enum logic [1:0] {
		ST_LOAD  = 2'd0,
		ST_FETCH = 2'd1,
		ST_RUN   = 2'd2
	} decode_state_e;

endpackage

//--- design/conv_1x1_decode.sv
`timescale 1ns/1ps
`include "conv_1x1_defs.svh"

module conv_1x1_decode (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         in_valid,
	input  conv_1x1_ctrl_pkg::cnn_word_t in_word,
	output logic                         w_write,
	output cnn_data_pkg::cnn_data_t      w_data,
	output logic                         load_weights,
	output logic                         w_capture,
	output logic                         pix_valid,
	output cnn_data_pkg::cnn_pixel_t     pix
);

	// Terminal value for both counters
	localparam logic [`CNN_WPTR_WIDTH:0] CNT_LAST = (`CNN_WPTR_WIDTH + 1)'(`CNN_WEIGHT_NUM);

	conv_1x1_ctrl_pkg::decode_state_e state;
	logic [`CNN_WPTR_WIDTH:0]         w_cnt;
	logic [`CNN_WPTR_WIDTH:0]         f_cnt;
	// Ch0 word held, waiting for ch1
	logic                             half;
	cnn_data_pkg::cnn_data_t          ch0_q;
	logic                             is_weight;
	logic                             is_pixel;
	logic                             in_run;
	logic                             load_full;

	////////////////////////////////////////////////////////////
	// Word classification
	////////////////////////////////////////////////////////////

	assign is_weight = in_valid && (in_word.kind == conv_1x1_ctrl_pkg::KIND_WEIGHT);
	assign is_pixel  = in_valid && (in_word.kind == conv_1x1_ctrl_pkg::KIND_PIXEL);
	assign in_run    = (state == conv_1x1_ctrl_pkg::ST_RUN);
	assign load_full = (w_cnt == CNT_LAST);

	// Weights accepted in RUN or while the set is still short
	assign w_write = is_weight
		&& (in_run || (state == conv_1x1_ctrl_pkg::ST_LOAD && !load_full));
	assign w_data  = in_word.data;

	// Four pops, then one idle FETCH cycle for the last capture
	assign load_weights = (state == conv_1x1_ctrl_pkg::ST_FETCH) && (f_cnt != CNT_LAST);

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= conv_1x1_ctrl_pkg::ST_LOAD;
			w_cnt     <= '0;
			f_cnt     <= '0;
			half      <= 1'b0;
			pix_valid <= 1'b0;
			w_capture <= 1'b0;
		end else begin
			w_capture <= load_weights;
			pix_valid <= 1'b0;
			case (state)
				conv_1x1_ctrl_pkg::ST_LOAD: begin
					// Full set, input register drains this cycle
					if (load_full) begin
						state <= conv_1x1_ctrl_pkg::ST_FETCH;
						w_cnt <= '0;
						f_cnt <= '0;
					end else if (w_write) begin
						w_cnt <= w_cnt + 1'b1;
					end
				end
				conv_1x1_ctrl_pkg::ST_FETCH: begin
					if (f_cnt == CNT_LAST)
						state <= conv_1x1_ctrl_pkg::ST_RUN;
					else
						f_cnt <= f_cnt + 1'b1;
				end
				conv_1x1_ctrl_pkg::ST_RUN: begin
					// Reload, this word is weight one of the new set
					if (is_weight) begin
						state <= conv_1x1_ctrl_pkg::ST_LOAD;
						w_cnt <= (`CNN_WPTR_WIDTH + 1)'(1);
						half  <= 1'b0;
					end else if (is_pixel) begin
						pix_valid <= half;
						half      <= !half;
					end
				end
				default: state <= conv_1x1_ctrl_pkg::ST_LOAD;
			endcase
		end
	end

	// Pixel pairing, ch0 held then pair sent with ch1
	always_ff @(posedge clk) begin
		if (in_run && is_pixel) begin
			if (half) begin
				pix.ch0 <= ch0_q;
				pix.ch1 <= in_word.data;
			end else begin
				ch0_q <= in_word.data;
			end
		end
	end

	// A pair leaves only while RUN still holds
	assert property (@(posedge clk) disable iff (reset) pix_valid |-> in_run);
	// Fetch is one unbroken burst of four pops inside FETCH
	assert property (@(posedge clk) disable iff (reset)
		$rose(load_weights) |->
			(load_weights && state == conv_1x1_ctrl_pkg::ST_FETCH)[*4] ##1 !load_weights);

endmodule

//--- design/conv_1x1_defs.svh
`ifndef CONV_1X1_DEFS_SVH
`define CONV_1X1_DEFS_SVH

////////////////////////////////////////////////////////////
// Data widths, signed Q8.8
////////////////////////////////////////////////////////////

// Pixel and weight value
`define CNN_DATA_WIDTH 16
// Fraction bits of a value
`define CNN_FRAC_BITS 8
// One full product
`define CNN_PROD_WIDTH 32
// Two products plus carry
`define CNN_SUM_WIDTH 33

////////////////////////////////////////////////////////////
// Weight set, 2 in x 2 out x 1 x 1
////////////////////////////////////////////////////////////

`define CNN_WEIGHT_NUM 4
`define CNN_WPTR_WIDTH 2

`endif

//--- design/conv_1x1_execute.sv
`timescale 1ns/1ps
`include "conv_1x1_defs.svh"

module conv_1x1_execute (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        w_capture,
	input  cnn_data_pkg::cnn_data_t     buf_weight,
	input  logic                        pix_valid,
	input  cnn_data_pkg::cnn_pixel_t    pix,
	output logic                        sum_valid,
	output cnn_data_pkg::cnn_sum_pair_t sums
);

	// Order w00, w01, w10, w11
	cnn_data_pkg::cnn_data_t  weight [`CNN_WEIGHT_NUM];
	logic [`CNN_WPTR_WIDTH-1:0] widx;
	cnn_data_pkg::cnn_prod_t  prod [`CNN_WEIGHT_NUM];
	logic                     prod_valid;

	////////////////////////////////////////////////////////////
	// Weight registers
	////////////////////////////////////////////////////////////

	// Index wraps after four captures, ready for a reload
	always_ff @(posedge clk) begin
		if (reset)
			widx <= '0;
		else if (w_capture)
			widx <= widx + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (w_capture)
			weight[widx] <= buf_weight;
	end

	////////////////////////////////////////////////////////////
	// Two-stage multiply-add
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			sum_valid  <= 1'b0;
		end else begin
			prod_valid <= pix_valid;
			sum_valid  <= prod_valid;
		end
	end

	// Stage 1, full-width signed products
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			// Out ch0
			prod[0] <= weight[0] * pix.ch0;
			prod[1] <= weight[1] * pix.ch1;
			// Out ch1
			prod[2] <= weight[2] * pix.ch0;
			prod[3] <= weight[3] * pix.ch1;
		end
	end

	// Stage 2, guard bit keeps the sum exact
	always_ff @(posedge clk) begin
		if (prod_valid) begin
			sums.sum0 <= prod[0] + prod[1];
			sums.sum1 <= prod[2] + prod[3];
		end
	end

endmodule

//--- design/conv_1x1_result.sv
`timescale 1ns/1ps
`include "conv_1x1_defs.svh"

module conv_1x1_result (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        sum_valid,
	input  cnn_data_pkg::cnn_sum_pair_t sums,
	output logic                        out_valid,
	output cnn_data_pkg::cnn_pixel_t    out_pixel
);

	// Largest positive Q8.8 value, 32767
	localparam cnn_data_pkg::cnn_data_t DATA_MAX = {1'b0, {(`CNN_DATA_WIDTH - 1){1'b1}}};
	localparam cnn_data_pkg::cnn_sum_t  SAT_MAX  = cnn_data_pkg::cnn_sum_t'(DATA_MAX);

	////////////////////////////////////////////////////////////
	// ReLU, rescale from Q16.16 back to Q8.8, clamp
	////////////////////////////////////////////////////////////

	function automatic cnn_data_pkg::cnn_data_t relu_scale(input cnn_data_pkg::cnn_sum_t sum);
		cnn_data_pkg::cnn_sum_t shifted;
		shifted = sum >>> `CNN_FRAC_BITS;
		if (sum < 0)
			return '0;
		if (shifted > SAT_MAX)
			return DATA_MAX;
		return cnn_data_pkg::cnn_data_t'(shifted[`CNN_DATA_WIDTH-1:0]);
	endfunction

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= sum_valid;
	end

	always_ff @(posedge clk) begin
		if (sum_valid) begin
			out_pixel.ch0 <= relu_scale(sums.sum0);
			out_pixel.ch1 <= relu_scale(sums.sum1);
		end
	end

	// Weights and pixels upstream all known by the time a result leaves
	assert property (@(posedge clk) disable iff (reset) out_valid |-> !$isunknown(out_pixel));

endmodule

//--- design/conv_1x1_top.sv
`timescale 1ns/1ps

module conv_1x1_top (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         in_valid,
	input  conv_1x1_ctrl_pkg::cnn_word_t in_word,
	output logic                         out_valid,
	output cnn_data_pkg::cnn_pixel_t     out_pixel,
	output logic                         weights_loaded
);

	////////////////////////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////////////////////////

	// Weight path
	logic                        w_write;
	cnn_data_pkg::cnn_data_t     w_data;
	logic                        load_weights;
	logic                        w_capture;
	cnn_data_pkg::cnn_data_t     buf_weight;
	// Pixel path
	logic                        pix_valid;
	cnn_data_pkg::cnn_pixel_t    pix;
	logic                        sum_valid;
	cnn_data_pkg::cnn_sum_pair_t sums;

	// Stream split, FSM, pixel pairing
	conv_1x1_decode u_decode (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_word     (in_word),
		.w_write     (w_write),
		.w_data      (w_data),
		.load_weights(load_weights),
		.w_capture   (w_capture),
		.pix_valid   (pix_valid),
		.pix         (pix)
	);

	conv_1x1_buffer_weights u_buffer_weights (
		.clk           (clk),
		.reset         (reset),
		.w_write       (w_write),
		.w_data        (w_data),
		.load_weights  (load_weights),
		.buf_weight    (buf_weight),
		.weights_loaded(weights_loaded)
	);

	// Two cycles, pixel in to sums out
	conv_1x1_execute u_execute (
		.clk       (clk),
		.reset     (reset),
		.w_capture (w_capture),
		.buf_weight(buf_weight),
		.pix_valid (pix_valid),
		.pix       (pix),
		.sum_valid (sum_valid),
		.sums      (sums)
	);

	conv_1x1_result u_result (
		.clk      (clk),
		.reset    (reset),
		.sum_valid(sum_valid),
		.sums     (sums),
		.out_valid(out_valid),
		.out_pixel(out_pixel)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the conv_1x1 testbench with Verilator
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert -Wno-fatal \
	-f conv_1x1_top.f --top-module conv_1x1_tb -o conv_1x1_sim \
	&& ./obj_dir/conv_1x1_sim 2>&1)
echo "$out"

echo "$out" | grep -qx "Done: no errors" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verification/conv_1x1_tb.sv
`timescale 1ns/1ps
`include "conv_1x1_defs.svh"

module conv_1x1_tb;

	// One table row, stimulus plus what the row expects
	typedef struct packed {
		logic                         valid;
		conv_1x1_ctrl_pkg::cnn_word_t word;
		logic                         expect_out;
		cnn_data_pkg::cnn_pixel_t     exp_pix;
		logic                         chk_loaded;
		logic                         exp_loaded;
	} stim_entry_t;

	logic                         clk;
	logic                         reset;
	logic                         in_valid;
	conv_1x1_ctrl_pkg::cnn_word_t in_word;
	logic                         out_valid;
	cnn_data_pkg::cnn_pixel_t     out_pixel;
	logic                         weights_loaded;

	// Table and reference model state
	stim_entry_t              tbl [$];
	cnn_data_pkg::cnn_pixel_t exp_q [$];
	cnn_data_pkg::cnn_data_t  cur_w [`CNN_WEIGHT_NUM];
	cnn_data_pkg::cnn_data_t  pend_w [`CNN_WEIGHT_NUM];
	int                       pend_cnt;
	logic                     have_weights;
	logic [15:0]              lfsr_state;
	int                       cycle_count;
	int                       cycle_limit;

	conv_1x1_top uut (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_word       (in_word),
		.out_valid     (out_valid),
		.out_pixel     (out_pixel),
		.weights_loaded(weights_loaded)
	);

	// 40 ns period
	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Error reporting and checks
	////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_pixel(input string name, input cnn_data_pkg::cnn_pixel_t exp,
		input cnn_data_pkg::cnn_pixel_t act);
		if (act !== exp)
			stop_on_error($sformatf("[FAIL] %0t ns %s expected ch0=%h ch1=%h got ch0=%h ch1=%h",
				$time, name, exp.ch0, exp.ch1, act.ch0, act.ch1));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("[FAIL] %0t ns %s expected %b got %b",
				$time, name, exp, act));
	endtask

	// Every output pixel must match the oldest queued one
	task automatic check_outputs();
		if (out_valid) begin
			if (exp_q.size() == 0)
				stop_on_error("Unexpected output: out_valid went high with no pixel expected");
			else
				check_pixel("out_pixel", exp_q.pop_front(), out_pixel);
		end
	endtask

	// Run limit in clock cycles
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
			stop_on_error($sformatf("Timeout: run did not finish within %0d clock cycles",
				cycle_limit));
	end

	////////////////////////////////////////////////////////////
	// Random values and reference model
	////////////////////////////////////////////////////////////

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	// 12 random bits, sign extended, about +-8.0 in Q8.8
	function automatic cnn_data_pkg::cnn_data_t random_value();
		logic [11:0] bits;
		bits = '0;
		for (int i = 0; i < 12; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			bits = {bits[10:0], lfsr_state[0]};
		end
		return {{4{bits[11]}}, bits};
	endfunction

	// Negative to zero, Q16.16 back to Q8.8, clamp at 32767
	function automatic cnn_data_pkg::cnn_data_t activate(input longint sum);
		longint scaled;
		if (sum < 0)
			return '0;
		scaled = sum / (longint'(1) << `CNN_FRAC_BITS);
		if (scaled > 32767)
			return 16'h7FFF;
		return cnn_data_pkg::cnn_data_t'(scaled);
	endfunction

	// Out ch o = w(o,0) * ch0 + w(o,1) * ch1
	function automatic cnn_data_pkg::cnn_pixel_t expected_pixel(
		input cnn_data_pkg::cnn_data_t a, input cnn_data_pkg::cnn_data_t b);
		cnn_data_pkg::cnn_pixel_t p;
		p.ch0 = activate(longint'(cur_w[0]) * longint'(a) + longint'(cur_w[1]) * longint'(b));
		p.ch1 = activate(longint'(cur_w[2]) * longint'(a) + longint'(cur_w[3]) * longint'(b));
		return p;
	endfunction

	////////////////////////////////////////////////////////////
	// Table building
	////////////////////////////////////////////////////////////

	// Fourth word of a set makes it the current set
	task automatic weight_entry(input cnn_data_pkg::cnn_data_t v);
		stim_entry_t e;
		e = '0;
		e.valid     = 1'b1;
		e.word.kind = conv_1x1_ctrl_pkg::KIND_WEIGHT;
		e.word.data = v;
		tbl.push_back(e);
		pend_w[pend_cnt] = v;
		pend_cnt++;
		if (pend_cnt == `CNN_WEIGHT_NUM) begin
			cur_w        = pend_w;
			pend_cnt     = 0;
			have_weights = 1'b1;
		end
	endtask

	// Lone pixel word, never completes a pair by itself
	task automatic half_pixel(input cnn_data_pkg::cnn_data_t v);
		stim_entry_t e;
		e = '0;
		e.valid     = 1'b1;
		e.word.kind = conv_1x1_ctrl_pkg::KIND_PIXEL;
		e.word.data = v;
		tbl.push_back(e);
	endtask

	// Ch1 word carries the expected output
	task automatic pixel_pair(input cnn_data_pkg::cnn_data_t a, input cnn_data_pkg::cnn_data_t b);
		stim_entry_t e;
		half_pixel(a);
		e = '0;
		e.valid      = 1'b1;
		e.word.kind  = conv_1x1_ctrl_pkg::KIND_PIXEL;
		e.word.data  = b;
		e.expect_out = have_weights;
		if (have_weights)
			e.exp_pix = expected_pixel(a, b);
		tbl.push_back(e);
	endtask

	// Idle rows, last one may check the loaded flag
	task automatic idle_gap(input int n, input logic chk);
		stim_entry_t e;
		for (int i = 0; i < n; i++) begin
			e = '0;
			if (i == n - 1) begin
				e.chk_loaded = chk;
				e.exp_loaded = have_weights;
			end
			tbl.push_back(e);
		end
	endtask

	task automatic build_table();
		// Pixels before any weights, all dropped
		idle_gap(4, 1'b1);
		half_pixel(16'h0100);
		pixel_pair(16'h0200, 16'h0300);
		idle_gap(2, 1'b1);
		// Set 1, w00=1.0 w01=0.5 w10=-0.75 w11=0.25
		weight_entry(16'h0100);
		weight_entry(16'h0080);
		weight_entry(16'hFF40);
		weight_entry(16'h0040);
		idle_gap(8, 1'b1);
		// Directed, ch1 goes negative and clips to zero
		pixel_pair(16'h0200, 16'h0100);
		pixel_pair(16'h0100, 16'h0400);
		pixel_pair(16'h0400, 16'h0000);
		idle_gap(3, 1'b0);
		// Back-to-back random pairs, pipeline full
		for (int i = 0; i < 12; i++)
			pixel_pair(random_value(), random_value());
		idle_gap(2, 1'b0);
		// Half pair left pending, then reload mid-stream
		half_pixel(random_value());
		// Set 2, large weights for saturation
		weight_entry(16'h7FFF);
		weight_entry(16'h7FFF);
		weight_entry(16'h8000);
		weight_entry(16'h0100);
		idle_gap(8, 1'b1);
		pixel_pair(16'h7FFF, 16'h7FFF);
		pixel_pair(16'h8000, 16'h8000);
		for (int i = 0; i < 8; i++)
			pixel_pair(random_value(), random_value());
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus loop
	////////////////////////////////////////////////////////////

	// Outputs sampled, then next row driven, on the falling edge
	task automatic apply_entry(input stim_entry_t e);
		@(negedge clk);
		check_outputs();
		if (e.chk_loaded)
			check_flag("weights_loaded", e.exp_loaded, weights_loaded);
		in_valid = e.valid;
		in_word  = e.word;
		if (e.expect_out)
			exp_q.push_back(e.exp_pix);
	endtask

	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		in_valid     = 1'b0;
		in_word      = '0;
		lfsr_state   = 16'd40946;
		pend_cnt     = 0;
		have_weights = 1'b0;
		cycle_count  = 0;
		build_table();
		cycle_limit = (tbl.size() + 40) * 2;

		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_flag("out_valid", 1'b0, out_valid);
		check_flag("weights_loaded", 1'b0, weights_loaded);

		foreach (tbl[i])
			apply_entry(tbl[i]);

		// Drain the pipeline
		@(negedge clk);
		check_outputs();
		in_valid = 1'b0;
		while (exp_q.size() > 0) begin
			@(negedge clk);
			check_outputs();
		end
		// Quiet tail, nothing extra may appear
		repeat (8) begin
			@(negedge clk);
			check_outputs();
		end
		check_flag("weights_loaded", 1'b1, weights_loaded);

		$display("Done: no errors");
		$finish;
	end

endmodule
